// ==== verilog/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  // ============================================================
  // Bus and bank widths
  // ============================================================

  // CPU bus address and data
  typedef logic [15:0] addr_t;
  typedef logic [7:0] byte_t;

  // Physical addresses, sized for the largest cartridge
  typedef logic [22:0] rom_addr_t;
  typedef logic [16:0] sram_addr_t;

  // Bank numbers, up to 512 ROM banks and 16 RAM banks
  typedef logic [8:0] rom_bank_t;
  typedef logic [3:0] ram_bank_t;

  // Controller chosen by header byte 0x0147
  typedef enum logic [1:0] {
    CART_ROM_ONLY,
    CART_MBC1,
    CART_MBC3
  } cart_type_t;

  // ============================================================
  // Address map
  // ============================================================

  localparam int unsigned ROM_BANK_SIZE = 16384;
  localparam int unsigned RAM_BANK_SIZE = 8192;

  localparam addr_t ROM_START = 16'h0000;
  localparam addr_t ROM_END = 16'h7FFF;
  localparam addr_t ROM_BANKED_START = 16'h4000;
  localparam addr_t ERAM_START = 16'hA000;
  localparam addr_t ERAM_END = 16'hBFFF;

  // Header bytes captured during ROM load
  localparam addr_t HDR_TYPE_ADDR = 16'h0147;
  localparam addr_t HDR_ROM_SIZE_ADDR = 16'h0148;

endpackage

`default_nettype wire

// ==== verilog/mbc1_regs.sv ====
`default_nettype none

module mbc1_regs (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              reg_we,
  input  wire cart_pkg::addr_t   addr,
  input  wire cart_pkg::byte_t   wdata,
  output cart_pkg::rom_bank_t    rom_bank,
  output cart_pkg::ram_bank_t    ram_bank,
  output logic                   ram_enable
);

  logic [4:0] lower_bank;
  logic [1:0] upper_bank;
  logic       bank_mode;
  logic [4:0] lower_fixed;

  // ============================================================
  // Register writes, decoded on addr[14:13]
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ram_enable <= 1'b0;
      lower_bank <= 5'd0;
      upper_bank <= 2'd0;
      bank_mode  <= 1'b0;
    end else if (reg_we) begin
      case (addr[14:13])
        // 0x0000-0x1FFF
        2'd0: ram_enable <= (wdata[3:0] == 4'hA);
        // 0x2000-0x3FFF
        2'd1: lower_bank <= wdata[4:0];
        // 0x4000-0x5FFF
        2'd2: upper_bank <= wdata[1:0];
        // 0x6000-0x7FFF
        default: bank_mode <= wdata[0];
      endcase
    end
  end

  // ============================================================
  // Bank outputs
  // ============================================================

  // Lower bank 0 behaves as bank 1
  assign lower_fixed = (lower_bank == 5'd0) ? 5'd1 : lower_bank;

  assign rom_bank = cart_pkg::rom_bank_t'({upper_bank, lower_fixed});

  // Upper bits reach the RAM only in mode 1
  assign ram_bank = bank_mode ? cart_pkg::ram_bank_t'(upper_bank) : '0;

endmodule

`default_nettype wire

// ==== verilog/mbc3_regs.sv ====
`default_nettype none

module mbc3_regs (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              reg_we,
  input  wire cart_pkg::addr_t   addr,
  input  wire cart_pkg::byte_t   wdata,
  output cart_pkg::rom_bank_t    rom_bank,
  output cart_pkg::ram_bank_t    ram_bank,
  output logic                   ram_enable
);

  logic [6:0] rom_bank_sel;
  logic [1:0] ram_bank_sel;

  // ============================================================
  // Register writes, decoded on addr[14:13]
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ram_enable   <= 1'b0;
      rom_bank_sel <= 7'd0;
      ram_bank_sel <= 2'd0;
    end else if (reg_we) begin
      case (addr[14:13])
        2'd0: ram_enable <= (wdata[3:0] == 4'hA);
        2'd1: rom_bank_sel <= wdata[6:0];
        2'd2: begin
          // RTC selects 0x08-0x0C fall outside and leave the bank alone
          if (wdata <= 8'h03) begin
            ram_bank_sel <= wdata[1:0];
          end
        end
        // Clock latch, no RTC here
        default: ;
      endcase
    end
  end

  // ============================================================
  // Bank outputs
  // ============================================================

  assign rom_bank = (rom_bank_sel == 7'd0) ? 9'd1 : cart_pkg::rom_bank_t'(rom_bank_sel);
  assign ram_bank = cart_pkg::ram_bank_t'(ram_bank_sel);

endmodule

`default_nettype wire

// ==== verilog/cart_mapper.sv ====
`default_nettype none

module cart_mapper #(
  parameter int unsigned ROM_BANKS = 16
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire cart_pkg::addr_t       addr,
  input  wire cart_pkg::byte_t       wdata,
  input  wire logic                  read_en,
  input  wire logic                  write_en,
  output cart_pkg::byte_t            rdata,
  input  wire logic                  rom_load_en,
  input  wire cart_pkg::rom_addr_t   rom_load_addr,
  input  wire cart_pkg::byte_t       rom_load_data,
  output logic                       mbc1_we,
  output logic                       mbc3_we,
  input  wire cart_pkg::rom_bank_t   mbc1_rom_bank,
  input  wire cart_pkg::ram_bank_t   mbc1_ram_bank,
  input  wire logic                  mbc1_ram_enable,
  input  wire cart_pkg::rom_bank_t   mbc3_rom_bank,
  input  wire cart_pkg::ram_bank_t   mbc3_ram_bank,
  input  wire logic                  mbc3_ram_enable,
  output cart_pkg::rom_addr_t        rom_addr,
  input  wire cart_pkg::byte_t       rom_rdata,
  output logic                       sram_we,
  output cart_pkg::sram_addr_t       sram_addr,
  output cart_pkg::byte_t            sram_wdata,
  input  wire cart_pkg::byte_t       sram_rdata
);

  localparam logic [9:0] ROM_BANKS_LIMIT = 10'(ROM_BANKS);

  cart_pkg::byte_t     hdr_type;
  cart_pkg::byte_t     hdr_rom_size;
  cart_pkg::cart_type_t cart_type;
  cart_pkg::rom_bank_t act_rom_bank;
  cart_pkg::ram_bank_t act_ram_bank;
  cart_pkg::rom_bank_t eff_rom_bank;
  logic                act_ram_enable;
  logic                ram_ok;
  logic [9:0]          size_banks;
  logic [9:0]          bank_limit;

  wire rom_sel  = addr inside {[cart_pkg::ROM_START : cart_pkg::ROM_END]};
  wire eram_sel = addr inside {[cart_pkg::ERAM_START : cart_pkg::ERAM_END]};

  // ============================================================
  // Header capture and cartridge type
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hdr_type     <= 8'h00;
      hdr_rom_size <= 8'h00;
    end else if (rom_load_en) begin
      if (rom_load_addr == cart_pkg::rom_addr_t'(cart_pkg::HDR_TYPE_ADDR)) begin
        hdr_type <= rom_load_data;
      end
      if (rom_load_addr == cart_pkg::rom_addr_t'(cart_pkg::HDR_ROM_SIZE_ADDR)) begin
        hdr_rom_size <= rom_load_data;
      end
    end
  end

  always_comb begin
    case (hdr_type)
      8'h01, 8'h02, 8'h03: cart_type = cart_pkg::CART_MBC1;
      8'h0F, 8'h10, 8'h11, 8'h12, 8'h13: cart_type = cart_pkg::CART_MBC3;
      default: cart_type = cart_pkg::CART_ROM_ONLY;
    endcase
  end

  // ============================================================
  // Active controller and bank limit
  // ============================================================

  always_comb begin
    case (cart_type)
      cart_pkg::CART_MBC1: begin
        act_rom_bank   = mbc1_rom_bank;
        act_ram_bank   = mbc1_ram_bank;
        act_ram_enable = mbc1_ram_enable;
      end
      cart_pkg::CART_MBC3: begin
        act_rom_bank   = mbc3_rom_bank;
        act_ram_bank   = mbc3_ram_bank;
        act_ram_enable = mbc3_ram_enable;
      end
      default: begin
        act_rom_bank   = 9'd1;
        act_ram_bank   = '0;
        act_ram_enable = 1'b0;
      end
    endcase
  end

  // Size byte n means 2 << n banks, 8 and above taken as 512
  assign size_banks = (hdr_rom_size > 8'd8) ? 10'd512 : (10'd2 << hdr_rom_size[3:0]);
  assign bank_limit = (size_banks < ROM_BANKS_LIMIT) ? size_banks : ROM_BANKS_LIMIT;

  // Both limits are powers of two, so the modulo is a mask
  assign eff_rom_bank = act_rom_bank & cart_pkg::rom_bank_t'(bank_limit - 10'd1);
  assign ram_ok = act_ram_enable && (cart_type != cart_pkg::CART_ROM_ONLY);

  // ============================================================
  // Address forming, strobes and read data
  // ============================================================

  // bank * 16 KiB + offset is the bank above the low 14 address bits
  assign rom_addr = (addr < cart_pkg::ROM_BANKED_START) ? cart_pkg::rom_addr_t'(addr)
                                                        : {eff_rom_bank, addr[13:0]};
  assign sram_addr  = {act_ram_bank, addr[12:0]};
  assign sram_wdata = wdata;
  assign sram_we    = write_en && eram_sel && ram_ok;

  assign mbc1_we = write_en && rom_sel && (cart_type == cart_pkg::CART_MBC1);
  assign mbc3_we = write_en && rom_sel && (cart_type == cart_pkg::CART_MBC3);

  always_comb begin
    rdata = 8'hFF;
    if (read_en) begin
      if (rom_sel) begin
        rdata = rom_rdata;
      end else if (eram_sel && ram_ok) begin
        rdata = sram_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cart_memory.sv ====
`default_nettype none

module cart_memory #(
  parameter int unsigned ROM_BANKS = 16,
  parameter int unsigned RAM_BANKS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rom_load_en,
  input  wire cart_pkg::rom_addr_t   rom_load_addr,
  input  wire cart_pkg::byte_t       rom_load_data,
  input  wire cart_pkg::rom_addr_t   rom_addr,
  output cart_pkg::byte_t            rom_rdata,
  input  wire logic                  sram_we,
  input  wire cart_pkg::sram_addr_t  sram_addr,
  input  wire cart_pkg::byte_t       sram_wdata,
  output cart_pkg::byte_t            sram_rdata
);

  localparam int unsigned ROM_BYTES = ROM_BANKS * cart_pkg::ROM_BANK_SIZE;
  localparam int unsigned RAM_BYTES = RAM_BANKS * cart_pkg::RAM_BANK_SIZE;
  localparam int unsigned ROM_AW = $clog2(ROM_BYTES);
  localparam int unsigned RAM_AW = $clog2(RAM_BYTES);

  cart_pkg::byte_t rom_mem [ROM_BYTES];
  cart_pkg::byte_t sram_mem [RAM_BYTES];

  wire load_in_range = rom_load_addr < cart_pkg::rom_addr_t'(ROM_BYTES);
  wire rom_in_range  = rom_addr < cart_pkg::rom_addr_t'(ROM_BYTES);
  wire sram_in_range = sram_addr < cart_pkg::sram_addr_t'(RAM_BYTES);

  // ============================================================
  // ROM, written only from the load port
  // ============================================================

  always_ff @(posedge clk) begin
    if (rom_load_en && load_in_range) begin
      rom_mem[rom_load_addr[ROM_AW-1:0]] <= rom_load_data;
    end
  end

  assign rom_rdata = rom_in_range ? rom_mem[rom_addr[ROM_AW-1:0]] : 8'hFF;

  // ============================================================
  // Banked SRAM
  // ============================================================

  always_ff @(posedge clk) begin
    if (sram_we && sram_in_range) begin
      sram_mem[sram_addr[RAM_AW-1:0]] <= sram_wdata;
    end
  end

  // Open bus above the fitted RAM
  assign sram_rdata = sram_in_range ? sram_mem[sram_addr[RAM_AW-1:0]] : 8'hFF;

endmodule

`default_nettype wire

// ==== verilog/cart_top.sv ====
`default_nettype none

module cart_top #(
  parameter int unsigned ROM_BANKS = 16,
  parameter int unsigned RAM_BANKS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire cart_pkg::addr_t       addr,
  input  wire cart_pkg::byte_t       wdata,
  output cart_pkg::byte_t            rdata,
  input  wire logic                  read_en,
  input  wire logic                  write_en,
  input  wire logic                  rom_load_en,
  input  wire cart_pkg::rom_addr_t   rom_load_addr,
  input  wire cart_pkg::byte_t       rom_load_data
);

  logic                 mbc1_we;
  logic                 mbc3_we;
  cart_pkg::rom_bank_t  mbc1_rom_bank;
  cart_pkg::ram_bank_t  mbc1_ram_bank;
  logic                 mbc1_ram_enable;
  cart_pkg::rom_bank_t  mbc3_rom_bank;
  cart_pkg::ram_bank_t  mbc3_ram_bank;
  logic                 mbc3_ram_enable;
  cart_pkg::rom_addr_t  rom_addr;
  cart_pkg::byte_t      rom_rdata;
  logic                 sram_we;
  cart_pkg::sram_addr_t sram_addr;
  cart_pkg::byte_t      sram_wdata;
  cart_pkg::byte_t      sram_rdata;

  cart_memory #(
    .ROM_BANKS(ROM_BANKS),
    .RAM_BANKS(RAM_BANKS)
  ) u_memory (
    .clk(clk), .rom_load_en(rom_load_en), .rom_load_addr(rom_load_addr),
    .rom_load_data(rom_load_data), .rom_addr(rom_addr), .rom_rdata(rom_rdata),
    .sram_we(sram_we), .sram_addr(sram_addr), .sram_wdata(sram_wdata),
    .sram_rdata(sram_rdata)
  );

  // Both controllers run side by side, the mapper picks one
  mbc1_regs u_mbc1 (
    .clk(clk), .reset(reset), .reg_we(mbc1_we), .addr(addr), .wdata(wdata),
    .rom_bank(mbc1_rom_bank), .ram_bank(mbc1_ram_bank), .ram_enable(mbc1_ram_enable)
  );

  mbc3_regs u_mbc3 (
    .clk(clk), .reset(reset), .reg_we(mbc3_we), .addr(addr), .wdata(wdata),
    .rom_bank(mbc3_rom_bank), .ram_bank(mbc3_ram_bank), .ram_enable(mbc3_ram_enable)
  );

  cart_mapper #(
    .ROM_BANKS(ROM_BANKS)
  ) u_mapper (
    .clk(clk), .reset(reset), .addr(addr), .wdata(wdata), .read_en(read_en),
    .write_en(write_en), .rdata(rdata), .rom_load_en(rom_load_en),
    .rom_load_addr(rom_load_addr), .rom_load_data(rom_load_data),
    .mbc1_we(mbc1_we), .mbc3_we(mbc3_we),
    .mbc1_rom_bank(mbc1_rom_bank), .mbc1_ram_bank(mbc1_ram_bank),
    .mbc1_ram_enable(mbc1_ram_enable), .mbc3_rom_bank(mbc3_rom_bank),
    .mbc3_ram_bank(mbc3_ram_bank), .mbc3_ram_enable(mbc3_ram_enable),
    .rom_addr(rom_addr), .rom_rdata(rom_rdata), .sram_we(sram_we),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
  );

endmodule

`default_nettype wire

// ==== tb/cart_assert.sv ====
`default_nettype none

module cart_assert (
  input wire logic                 clk,
  input wire logic                 reset,
  input wire cart_pkg::addr_t      addr,
  input wire logic                 read_en,
  input wire cart_pkg::byte_t      rdata,
  input wire logic                 sram_we,
  input wire cart_pkg::byte_t      hdr_type,
  input wire logic                 mbc1_ram_enable,
  input wire logic                 mbc3_ram_enable,
  input wire cart_pkg::cart_type_t cart_type,
  input wire cart_pkg::rom_bank_t  act_rom_bank
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed properties so far
  int unsigned fail_count = 0;

  // RAM enable of the controller named by the raw header byte
  wire hdr_mbc1 = (hdr_type >= 8'h01) && (hdr_type <= 8'h03);
  wire hdr_mbc3 = (hdr_type >= 8'h0F) && (hdr_type <= 8'h13);
  wire ram_allowed = (hdr_mbc1 && mbc1_ram_enable) || (hdr_mbc3 && mbc3_ram_enable);

  // ============================================================
  // Mapper properties
  // ============================================================

  // Idle bus floats high
  idle_reads_ff: assert property (@(posedge clk) disable iff (reset)
    !read_en |-> rdata == 8'hFF)
    else begin
      $error("rdata is not 0xFF while read_en is low");
      fail_count++;
    end

  sram_write_needs_enable: assert property (@(posedge clk) disable iff (reset)
    sram_we |-> ram_allowed)
    else begin
      $error("SRAM written while RAM is disabled");
      fail_count++;
    end

  // Controller bank for the switchable window, before the size mask
  banked_window_not_zero: assert property (@(posedge clk) disable iff (reset)
    (cart_type != cart_pkg::CART_ROM_ONLY && addr >= cart_pkg::ROM_BANKED_START &&
     addr <= cart_pkg::ROM_END) |-> act_rom_bank != '0)
    else begin
      $error("bank 0 selected for the 0x4000-0x7FFF window");
      fail_count++;
    end

endmodule

bind cart_mapper cart_assert u_assert (
  .clk(clk), .reset(reset), .addr(addr), .read_en(read_en), .rdata(rdata),
  .sram_we(sram_we), .hdr_type(hdr_type), .mbc1_ram_enable(mbc1_ram_enable),
  .mbc3_ram_enable(mbc3_ram_enable), .cart_type(cart_type),
  .act_rom_bank(act_rom_bank)
);

`default_nettype wire

// ==== tb/cart_tb.sv ====
`default_nettype none

module cart_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ROM_BANKS = 16;
  localparam int unsigned RAM_BANKS = 4;
  localparam int NUM_TESTS = 5;
  localparam int LOAD_CYCLES = ROM_BANKS * cart_pkg::ROM_BANK_SIZE + 2;
  localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (LOAD_CYCLES + 400) * 100 * 2;

  logic                clk = 1'b0;
  logic                reset;
  cart_pkg::addr_t     addr;
  cart_pkg::byte_t     wdata;
  cart_pkg::byte_t     rdata;
  logic                read_en;
  logic                write_en;
  logic                rom_load_en;
  cart_pkg::rom_addr_t rom_load_addr;
  cart_pkg::byte_t     rom_load_data;

  // Cartridge state tracked by the testbench
  cart_pkg::byte_t hdr_type;
  cart_pkg::byte_t hdr_size;
  logic            m1_ram_en;
  logic [4:0]      m1_lower;
  logic [1:0]      m1_upper;
  logic            m1_mode;
  logic            m3_ram_en;
  logic [6:0]      m3_rom;
  logic [1:0]      m3_ram;
  cart_pkg::byte_t sram_model [int];

  string test_name;
  bit    checking = 1'b0;
  int    checks = 0;
  int    errors = 0;
  int    test_checks = 0;
  int    test_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  cart_top #(
    .ROM_BANKS(ROM_BANKS),
    .RAM_BANKS(RAM_BANKS)
  ) i_dut (
    .clk(clk), .reset(reset), .addr(addr), .wdata(wdata), .rdata(rdata),
    .read_en(read_en), .write_en(write_en), .rom_load_en(rom_load_en),
    .rom_load_addr(rom_load_addr), .rom_load_data(rom_load_data)
  );

  always #50 clk = ~clk;

  // ============================================================
  // Reference model
  // ============================================================

  function automatic cart_pkg::cart_type_t decode_type(cart_pkg::byte_t t);
    if (t inside {[8'h01 : 8'h03]}) return cart_pkg::CART_MBC1;
    if (t inside {[8'h0F : 8'h13]}) return cart_pkg::CART_MBC3;
    return cart_pkg::CART_ROM_ONLY;
  endfunction

  // Fill pattern, header bytes come from the current test
  function automatic int rom_pattern(int phys);
    if (phys == int'(cart_pkg::HDR_TYPE_ADDR)) return hdr_type;
    if (phys == int'(cart_pkg::HDR_ROM_SIZE_ADDR)) return hdr_size;
    return (phys & 'hFF) ^ ((phys / 16384 * 'h35) & 'hFF);
  endfunction

  function automatic int rom_bank_now();
    int bank;
    int limit;
    case (decode_type(hdr_type))
      cart_pkg::CART_MBC1: bank = m1_upper * 32 + ((m1_lower == 5'd0) ? 1 : m1_lower);
      cart_pkg::CART_MBC3: bank = (m3_rom == 7'd0) ? 1 : m3_rom;
      default: return 1;
    endcase
    limit = (hdr_size >= 8'd8) ? 512 : (2 << hdr_size);
    if (limit > ROM_BANKS) limit = ROM_BANKS;
    return bank % limit;
  endfunction

  function automatic bit ram_on();
    case (decode_type(hdr_type))
      cart_pkg::CART_MBC1: return m1_ram_en;
      cart_pkg::CART_MBC3: return m3_ram_en;
      default: return 1'b0;
    endcase
  endfunction

  function automatic int ram_phys(cart_pkg::addr_t a);
    int bank;
    case (decode_type(hdr_type))
      cart_pkg::CART_MBC1: bank = m1_mode ? m1_upper : 0;
      cart_pkg::CART_MBC3: bank = m3_ram;
      default: bank = 0;
    endcase
    return bank * 8192 + (a - cart_pkg::ERAM_START);
  endfunction

  function automatic bit in_eram(cart_pkg::addr_t a);
    return a >= cart_pkg::ERAM_START && a <= cart_pkg::ERAM_END;
  endfunction

  // Expected rdata, -1 where the SRAM byte was never written
  function automatic int expected_read(cart_pkg::addr_t a, logic rd);
    int phys;
    if (!rd) return 'hFF;
    if (a <= cart_pkg::ROM_END) begin
      if (a < cart_pkg::ROM_BANKED_START) begin
        phys = a;
      end else begin
        phys = rom_bank_now() * 16384 + (a - cart_pkg::ROM_BANKED_START);
      end
      return rom_pattern(phys);
    end
    if (in_eram(a) && ram_on()) begin
      phys = ram_phys(a);
      if (phys >= RAM_BANKS * 8192) return 'hFF;
      if (sram_model.exists(phys)) return sram_model[phys];
      return -1;
    end
    return 'hFF;
  endfunction

  function automatic void track_write(cart_pkg::addr_t a, cart_pkg::byte_t d);
    int phys;
    if (a <= cart_pkg::ROM_END) begin
      if (decode_type(hdr_type) == cart_pkg::CART_MBC1) begin
        if (a < 16'h2000) m1_ram_en = (d[3:0] == 4'hA);
        else if (a < 16'h4000) m1_lower = d[4:0];
        else if (a < 16'h6000) m1_upper = d[1:0];
        else m1_mode = d[0];
      end else if (decode_type(hdr_type) == cart_pkg::CART_MBC3) begin
        if (a < 16'h2000) m3_ram_en = (d[3:0] == 4'hA);
        else if (a < 16'h4000) m3_rom = d[6:0];
        else if (a < 16'h6000 && d <= 8'h03) m3_ram = d[1:0];
      end
    end else if (in_eram(a) && ram_on()) begin
      phys = ram_phys(a);
      if (phys < RAM_BANKS * 8192) sram_model[phys] = d;
    end
  endfunction

  // ============================================================
  // Compare on the rising edge, then track writes
  // ============================================================

  always @(posedge clk) begin : compare
    int exp_val;
    if (checking && !reset) begin
      exp_val = expected_read(addr, read_en);
      if (exp_val >= 0) begin
        checks++;
        test_checks++;
        assert (rdata == cart_pkg::byte_t'(exp_val)) else begin
          $display("[ERROR] %s: addr %h expected %h actual %h",
                   test_name, addr, cart_pkg::byte_t'(exp_val), rdata);
          errors++;
          test_errors++;
        end
      end
      if (write_en) track_write(addr, wdata);
    end
  end

  // ============================================================
  // Bus tasks
  // ============================================================

  task automatic bus_read(cart_pkg::addr_t a);
    @(negedge clk);
    addr = a;
    read_en = 1'b1;
    write_en = 1'b0;
  endtask

  task automatic bus_write(cart_pkg::addr_t a, cart_pkg::byte_t d);
    @(negedge clk);
    addr = a;
    wdata = d;
    read_en = 1'b0;
    write_en = 1'b1;
  endtask

  task automatic bus_idle(cart_pkg::addr_t a);
    @(negedge clk);
    addr = a;
    read_en = 1'b0;
    write_en = 1'b0;
  endtask

  function automatic cart_pkg::addr_t rand_rom_addr();
    return cart_pkg::addr_t'($urandom & 32'h7FFF);
  endfunction

  function automatic cart_pkg::addr_t rand_banked_addr();
    return cart_pkg::addr_t'(32'h4000 | ($urandom & 32'h3FFF));
  endfunction

  task automatic fill_rom();
    for (int i = 0; i < ROM_BANKS * cart_pkg::ROM_BANK_SIZE; i++) begin
      @(negedge clk);
      rom_load_en = 1'b1;
      rom_load_addr = cart_pkg::rom_addr_t'(i);
      rom_load_data = cart_pkg::byte_t'(rom_pattern(i));
    end
    @(negedge clk);
    rom_load_en = 1'b0;
  endtask

  task automatic begin_test(string name, cart_pkg::byte_t t, cart_pkg::byte_t s);
    test_name = name;
    checking = 1'b0;
    test_checks = 0;
    test_errors = 0;
    bus_idle(16'h0000);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    m1_ram_en = 1'b0;
    m1_lower = '0;
    m1_upper = '0;
    m1_mode = 1'b0;
    m3_ram_en = 1'b0;
    m3_rom = '0;
    m3_ram = '0;
    hdr_type = t;
    hdr_size = s;
    // Header goes into ROM and the mapper capture registers
    rom_load_en = 1'b1;
    rom_load_addr = cart_pkg::rom_addr_t'(cart_pkg::HDR_TYPE_ADDR);
    rom_load_data = t;
    @(negedge clk);
    rom_load_addr = cart_pkg::rom_addr_t'(cart_pkg::HDR_ROM_SIZE_ADDR);
    rom_load_data = s;
    @(negedge clk);
    rom_load_en = 1'b0;
    checking = 1'b1;
  endtask

  task automatic finish_test();
    bus_idle(16'h0000);
    @(negedge clk);
    checking = 1'b0;
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %-12s %s (%0d checks, %0d errors)", test_name,
             (test_errors == 0) ? "pass" : "fail", test_checks, test_errors);
  endtask

  // ============================================================
  // Tests
  // ============================================================

  task automatic test_rom_only();
    begin_test("rom_only", 8'h00, 8'h03);
    repeat (150) bus_read(rand_rom_addr());
    // Register writes must not bank anything
    bus_write(16'h0000, 8'h0A);
    bus_write(16'h2000, 8'h05);
    bus_write(16'h4000, 8'h01);
    bus_write(16'h6000, 8'h01);
    bus_write(16'hA000, 8'h5A);
    bus_read(16'hA000);
    repeat (100) bus_read(rand_rom_addr());
    finish_test();
  endtask

  task automatic test_mbc1_rom();
    cart_pkg::byte_t lowers [6] = '{8'h00, 8'h01, 8'h05, 8'h07, 8'h0B, 8'h1F};
    begin_test("mbc1_rom", 8'h01, 8'h02);
    foreach (lowers[i]) begin
      bus_write(16'h2000, lowers[i]);
      repeat (4) bus_read(rand_banked_addr());
      bus_read(16'h7FFF);
    end
    bus_write(16'h4000, 8'h01);
    bus_write(16'h3FFF, 8'h03);
    repeat (6) bus_read(rand_banked_addr());
    bus_write(16'h5FFF, 8'h03);
    bus_write(16'h2000, 8'h00);
    repeat (6) bus_read(rand_banked_addr());
    repeat (10) bus_read(cart_pkg::addr_t'($urandom & 32'h3FFF));
    finish_test();
  endtask

  task automatic test_mbc1_ram();
    cart_pkg::addr_t ram_addrs [8];
    begin_test("mbc1_ram", 8'h03, 8'h03);
    foreach (ram_addrs[i]) ram_addrs[i] = cart_pkg::addr_t'(32'hA000 | ($urandom & 32'h1FFF));
    // Disabled RAM drops writes and reads open bus
    bus_write(16'hA000, 8'h11);
    bus_read(16'hA000);
    bus_write(16'h0000, 8'h0A);
    bus_write(16'h4000, 8'h02);
    bus_write(16'hA010, 8'h3C);
    bus_read(16'hA010);
    bus_write(16'h6000, 8'h01);
    for (int b = 0; b < 4; b++) begin
      bus_write(16'h4000, cart_pkg::byte_t'(b));
      foreach (ram_addrs[i]) bus_write(ram_addrs[i], cart_pkg::byte_t'($urandom));
    end
    for (int b = 0; b < 4; b++) begin
      bus_write(16'h4000, cart_pkg::byte_t'(b));
      foreach (ram_addrs[i]) bus_read(ram_addrs[i]);
    end
    // Back to mode 0, bank 0 regardless of upper bits
    bus_write(16'h6000, 8'h00);
    foreach (ram_addrs[i]) bus_read(ram_addrs[i]);
    bus_write(16'h0000, 8'h00);
    bus_write(16'hA010, 8'h77);
    bus_read(16'hA010);
    finish_test();
  endtask

  task automatic test_mbc3();
    cart_pkg::byte_t banks [4] = '{8'h00, 8'h01, 8'h0B, 8'h7F};
    // Header claims 64 banks, more than the fitted ROM holds
    begin_test("mbc3", 8'h13, 8'h05);
    foreach (banks[i]) begin
      bus_write(16'h2000, banks[i]);
      repeat (4) bus_read(rand_banked_addr());
    end
    bus_write(16'h0000, 8'h0A);
    for (int b = 0; b < 4; b++) begin
      bus_write(16'h4000, cart_pkg::byte_t'(b));
      bus_write(16'hA100, cart_pkg::byte_t'(8'h40 + b));
      bus_read(16'hA100);
    end
    // RTC select and latch writes leave bank 3 in place
    bus_write(16'h4000, 8'h08);
    bus_read(16'hA100);
    bus_write(16'h6000, 8'h00);
    bus_write(16'h6000, 8'h01);
    bus_read(16'hA100);
    repeat (4) bus_read(rand_banked_addr());
    for (int b = 0; b < 4; b++) begin
      bus_write(16'h4000, cart_pkg::byte_t'(b));
      bus_read(16'hA100);
    end
    finish_test();
  endtask

  task automatic test_idle_mixed();
    cart_pkg::addr_t a;
    begin_test("idle_mixed", 8'h01, 8'h03);
    repeat (20) bus_idle(cart_pkg::addr_t'($urandom));
    bus_read(16'h8000);
    bus_read(16'h9FFF);
    bus_read(16'hC000);
    bus_read(16'hFFFF);
    repeat (10) bus_read(cart_pkg::addr_t'(32'hC000 | ($urandom & 32'h3FFF)));
    repeat (300) begin
      case ($urandom % 5)
        0: begin
          a = rand_rom_addr();
          bus_write(a, (a < 16'h2000 && $urandom % 2 == 0) ? 8'h0A : 8'($urandom));
        end
        1: bus_write(cart_pkg::addr_t'(32'hA000 | ($urandom & 32'h100F)), 8'($urandom));
        2: bus_read(cart_pkg::addr_t'(32'hA000 | ($urandom & 32'h100F)));
        3: bus_idle(cart_pkg::addr_t'($urandom));
        default: bus_read(rand_rom_addr());
      endcase
    end
    finish_test();
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin
    void'($urandom(32'hdacd_d1aa));
    reset = 1'b1;
    addr = '0;
    wdata = '0;
    read_en = 1'b0;
    write_en = 1'b0;
    rom_load_en = 1'b0;
    rom_load_addr = '0;
    rom_load_data = '0;
    hdr_type = 8'h00;
    hdr_size = 8'h00;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    fill_rom();
    test_rom_only();
    test_mbc1_rom();
    test_mbc1_ram();
    test_mbc3();
    test_idle_mixed();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, i_dut.u_mapper.u_assert.fail_count);
    if (errors == 0 && tests_failed == 0 && i_dut.u_mapper.u_assert.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/cart_pkg.sv
verilog/mbc1_regs.sv
verilog/mbc3_regs.sv
verilog/cart_mapper.sv
verilog/cart_memory.sv
verilog/cart_top.sv
tb/cart_assert.sv
tb/cart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cart_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
